// ==== src/mdio_frame_if.sv ====
// MDIO frame channel
// Received frame word and event strobes from the frontend, read response back
`timescale 1ns/1ps
interface mdio_frame_if
    import mdio_pkg::*;
();
    mdio_frame_u rx_data;
    logic        phyaddr_done;
    logic        info_done;
    logic        data_done;
    logic        time_out;
    logic        legal;
    logic [15:0] resp_rdata;
    logic        resp_ready;

    modport frontend (
        output rx_data, phyaddr_done, info_done, data_done, time_out, legal,
        input  resp_rdata, resp_ready
    );

    modport backend (
        input  rx_data, phyaddr_done, info_done, data_done, time_out, legal,
        output resp_rdata, resp_ready
    );

endinterface

// ==== src/mdio_phy_regs.sv ====
// PHY register store
// 128 words indexed by the aliasing rule, answers one cycle after valid
`timescale 1ns/1ps
module mdio_phy_regs
    import mdio_pkg::*;
(
    input  logic      clk_25m,
    input  logic      rst_n,
    mdio_reg_if.slave reg_bus
);

    logic [15:0] mem [128];
    logic [6:0]  idx;

    assign idx = reg_index(reg_bus.addr);

    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            reg_bus.ready <= 1'b0;
            reg_bus.rdata <= 16'h0;
            for (int i = 0; i < 128; i++) begin
                mem[i] <= 16'h0;
            end
        end else begin
            // One request per valid, ready drops after the handshake
            reg_bus.ready <= reg_bus.valid && !reg_bus.ready;
            if (reg_bus.valid && !reg_bus.ready) begin
                reg_bus.rdata <= mem[idx];
                if (reg_bus.we) begin
                    mem[idx] <= reg_bus.wdata;
                end
            end
        end
    end

endmodule

// ==== src/mdio_pkg.sv ====
// MDIO slave shared definitions
// Frame layout, start codes, opcodes and register indexing
package mdio_pkg;

    // Start codes
    localparam logic [1:0] ST_CL45 = 2'b00;
    localparam logic [1:0] ST_CL22 = 2'b01;

    // Clause 22 opcodes
    localparam logic [1:0] OP22_WRITE = 2'b01;
    localparam logic [1:0] OP22_READ  = 2'b10;

    // Clause 45 opcodes
    localparam logic [1:0] OP45_ADDR  = 2'b00;
    localparam logic [1:0] OP45_WRITE = 2'b01;
    localparam logic [1:0] OP45_PRINC = 2'b10;
    localparam logic [1:0] OP45_READ  = 2'b11;

    // Register address is devad followed by 16 address bits
    localparam int REG_ADDR_W = 21;

    // Frame word after the preamble, bit 31 arrives first
    typedef union packed {
        struct packed {
            logic [1:0]  st;
            logic [1:0]  op;
            logic [4:0]  phyad;
            logic [4:0]  regad;
            logic [1:0]  ta;
            logic [15:0] data;
        } cl22;
        struct packed {
            logic [1:0]  st;
            logic [1:0]  op;
            logic [4:0]  prtad;
            logic [4:0]  devad;
            logic [1:0]  ta;
            logic [15:0] data;
        } cl45;
    } mdio_frame_u;

    // Store index from address bits 17:16 and 4:0
    function automatic logic [6:0] reg_index(input logic [REG_ADDR_W-1:0] addr);
        return {addr[17:16], addr[4:0]};
    endfunction

endpackage

// ==== src/mdio_reg_if.sv ====
// Register access channel
// Valid/ready request with address, write data and read data
`timescale 1ns/1ps
interface mdio_reg_if
    import mdio_pkg::*;
();
    logic [REG_ADDR_W-1:0] addr;
    logic [15:0]           wdata;
    logic                  we;
    logic                  valid;
    logic [15:0]           rdata;
    logic                  ready;

    modport master (output addr, wdata, we, valid, input rdata, ready);

    modport slave (input addr, wdata, we, valid, output rdata, ready);

endinterface

// ==== src/mdio_slave_22_backend.sv ====
// Clause 22 backend
// Issues a register read after the header and a write after the data field
`timescale 1ns/1ps
module mdio_slave_22_backend
    import mdio_pkg::*;
(
    input  logic        clk_25m,
    input  logic        rst_n,
    input  logic        enable,
    input  mdio_frame_u rx_data,
    input  logic        info_done,
    input  logic        data_done,
    output logic [15:0] resp_rdata,
    output logic        resp_ready,
    mdio_reg_if.master  reg_bus
);

    logic        rd_req;
    logic        wr_req;
    logic        rd_hs;
    logic        rd_done;
    logic [15:0] rdata_q;

    assign rd_req = enable && info_done && (rx_data.cl22.op == OP22_READ);
    assign wr_req = enable && data_done && (rx_data.cl22.op == OP22_WRITE);
    assign rd_hs  = reg_bus.valid && reg_bus.ready && !reg_bus.we;

    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            reg_bus.valid <= 1'b0;
            reg_bus.we    <= 1'b0;
            rd_done       <= 1'b0;
        end else begin
            if (reg_bus.valid && reg_bus.ready) begin
                reg_bus.valid <= 1'b0;
            end else if (rd_req || wr_req) begin
                reg_bus.valid <= 1'b1;
                reg_bus.we    <= wr_req;
            end
            // Response held until the frame ends
            if (!enable || data_done) begin
                rd_done <= 1'b0;
            end else if (rd_hs) begin
                rd_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_25m) begin
        if (rd_req || wr_req) begin
            reg_bus.addr  <= {16'h0, rx_data.cl22.regad};
            reg_bus.wdata <= rx_data.cl22.data;
        end
        if (rd_hs) begin
            rdata_q <= reg_bus.rdata;
        end
    end

    // Handshake cycle bypasses the latch
    assign resp_ready = rd_done || rd_hs;
    assign resp_rdata = rd_done ? rdata_q : reg_bus.rdata;

endmodule

// ==== src/mdio_slave_45_backend.sv ====
// Clause 45 backend
// Address, write, read and post-read-increment frames against a held
// 16-bit address register
`timescale 1ns/1ps
module mdio_slave_45_backend
    import mdio_pkg::*;
(
    input  logic        clk_25m,
    input  logic        rst_n,
    input  logic        enable,
    input  mdio_frame_u rx_data,
    input  logic        info_done,
    input  logic        data_done,
    output logic [15:0] resp_rdata,
    output logic        resp_ready,
    mdio_reg_if.master  reg_bus
);

    logic [15:0] addr_q;
    logic        addr_load;
    logic        rd_req;
    logic        wr_req;
    logic        rd_hs;
    logic        rd_done;
    logic [15:0] rdata_q;

    // Both read opcodes have op[1] set
    assign rd_req    = enable && info_done &&
                       ((rx_data.cl45.op == OP45_READ) || (rx_data.cl45.op == OP45_PRINC));
    assign wr_req    = enable && data_done && (rx_data.cl45.op == OP45_WRITE);
    assign addr_load = enable && data_done && (rx_data.cl45.op == OP45_ADDR);
    assign rd_hs     = reg_bus.valid && reg_bus.ready && !reg_bus.we;

    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            addr_q        <= '0;
            reg_bus.valid <= 1'b0;
            reg_bus.we    <= 1'b0;
            rd_done       <= 1'b0;
        end else begin
            if (addr_load) begin
                addr_q <= rx_data.cl45.data;
            end else if (rd_hs && rx_data.cl45.op == OP45_PRINC) begin
                // Post-read increment
                addr_q <= addr_q + 16'd1;
            end

            if (reg_bus.valid && reg_bus.ready) begin
                reg_bus.valid <= 1'b0;
            end else if (rd_req || wr_req) begin
                reg_bus.valid <= 1'b1;
                reg_bus.we    <= wr_req;
            end

            if (!enable || data_done) begin
                rd_done <= 1'b0;
            end else if (rd_hs) begin
                rd_done <= 1'b1;
            end
        end
    end

    // --------------------
    // Request and response payload
    always_ff @(posedge clk_25m) begin
        if (rd_req || wr_req) begin
            reg_bus.addr  <= {rx_data.cl45.devad, addr_q};
            reg_bus.wdata <= rx_data.cl45.data;
        end
        if (rd_hs) begin
            rdata_q <= reg_bus.rdata;
        end
    end

    assign resp_ready = rd_done || rd_hs;
    assign resp_rdata = rd_done ? rdata_q : reg_bus.rdata;

endmodule

// ==== src/mdio_slave_backend.sv ====
// MDIO backend dispatcher
// Latches the clause from the start code and routes frame events and
// register traffic to the Clause 22 or Clause 45 backend
`timescale 1ns/1ps
module mdio_slave_backend
    import mdio_pkg::*;
(
    input  logic          clk_25m,
    input  logic          rst_n,
    mdio_frame_if.backend frame,
    mdio_reg_if.master    reg_bus
);

    logic        cl22;
    logic        cl45;
    logic [15:0] cl22_resp_rdata;
    logic [15:0] cl45_resp_rdata;
    logic        cl22_resp_ready;
    logic        cl45_resp_ready;

    mdio_reg_if cl22_bus ();
    mdio_reg_if cl45_bus ();

    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            cl22 <= 1'b0;
            cl45 <= 1'b0;
        end else if (frame.time_out) begin
            cl22 <= 1'b0;
            cl45 <= 1'b0;
        end else if (frame.phyaddr_done) begin
            cl22 <= (frame.rx_data.cl22.st == ST_CL22);
            cl45 <= (frame.rx_data.cl45.st == ST_CL45);
        end
    end

    // --------------------
    // Clause select, zero when idle
    assign frame.resp_rdata = cl45 ? cl45_resp_rdata : cl22 ? cl22_resp_rdata : 16'h0;
    assign frame.resp_ready = cl45 ? cl45_resp_ready : cl22 ? cl22_resp_ready : 1'b0;
    assign reg_bus.addr     = cl45 ? cl45_bus.addr   : cl22 ? cl22_bus.addr   : '0;
    assign reg_bus.wdata    = cl45 ? cl45_bus.wdata  : cl22 ? cl22_bus.wdata  : 16'h0;
    assign reg_bus.we       = cl45 ? cl45_bus.we     : cl22 ? cl22_bus.we     : 1'b0;
    assign reg_bus.valid    = cl45 ? cl45_bus.valid  : cl22 ? cl22_bus.valid  : 1'b0;

    assign cl22_bus.rdata = reg_bus.rdata;
    assign cl22_bus.ready = reg_bus.ready & cl22;
    assign cl45_bus.rdata = reg_bus.rdata;
    assign cl45_bus.ready = reg_bus.ready & cl45;

    mdio_slave_22_backend i_cl22 (
        .clk_25m    (clk_25m),
        .rst_n      (rst_n),
        .enable     (cl22 & frame.legal),
        .rx_data    (frame.rx_data),
        .info_done  (frame.info_done),
        .data_done  (frame.data_done),
        .resp_rdata (cl22_resp_rdata),
        .resp_ready (cl22_resp_ready),
        .reg_bus    (cl22_bus)
    );

    mdio_slave_45_backend i_cl45 (
        .clk_25m    (clk_25m),
        .rst_n      (rst_n),
        .enable     (cl45 & frame.legal),
        .rx_data    (frame.rx_data),
        .info_done  (frame.info_done),
        .data_done  (frame.data_done),
        .resp_rdata (cl45_resp_rdata),
        .resp_ready (cl45_resp_ready),
        .reg_bus    (cl45_bus)
    );

endmodule

// ==== src/mdio_slave_frontend.sv ====
// MDIO serial frontend
// Samples mdc and mdio, finds the preamble, shifts the frame into a word,
// checks the PHY address and drives read data back out
`timescale 1ns/1ps
module mdio_slave_frontend #(
    parameter logic [4:0] PHY_ADDR       = 5'd3,
    parameter int         TIMEOUT_CYCLES = 64
) (
    input  logic           clk_25m,
    input  logic           rst_n,
    input  logic           mdc,
    input  logic           mdio_in,
    output logic           mdio_out,
    output logic           mdio_oe,
    mdio_frame_if.frontend frame
);

    localparam int TO_W = $clog2(TIMEOUT_CYCLES);

    logic [1:0]      mdc_sync;
    logic [1:0]      mdio_sync;
    logic            mdc_d;
    logic            mdc_rise;
    logic            mdc_fall;
    logic            mdio_bit;
    logic            in_frame;
    logic            frame_start;
    logic [5:0]      ones_cnt;
    logic [5:0]      bit_cnt;
    logic [TO_W-1:0] to_cnt;
    logic            drive;
    logic [15:0]     tx_shift;

    // --------------------
    // Input sync and edges
    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            mdc_sync  <= '0;
            mdio_sync <= '0;
            mdc_d     <= 1'b0;
        end else begin
            mdc_sync  <= {mdc_sync[0], mdc};
            mdio_sync <= {mdio_sync[0], mdio_in};
            mdc_d     <= mdc_sync[1];
        end
    end

    assign mdc_rise    = mdc_sync[1] & ~mdc_d;
    assign mdc_fall    = ~mdc_sync[1] & mdc_d;
    assign mdio_bit    = mdio_sync[1];
    // Zero after at least 32 ones is the first start bit
    assign frame_start = !in_frame && !mdio_bit && (ones_cnt == 6'd32);

    // --------------------
    // Frame receive
    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            in_frame           <= 1'b0;
            ones_cnt           <= '0;
            bit_cnt            <= '0;
            to_cnt             <= '0;
            frame.legal        <= 1'b0;
            frame.phyaddr_done <= 1'b0;
            frame.info_done    <= 1'b0;
            frame.data_done    <= 1'b0;
            frame.time_out     <= 1'b0;
        end else begin
            frame.phyaddr_done <= 1'b0;
            frame.info_done    <= 1'b0;
            frame.data_done    <= 1'b0;
            frame.time_out     <= 1'b0;
            if (in_frame && !mdc_rise && to_cnt == TO_W'(TIMEOUT_CYCLES - 1)) begin
                // mdc stalled, back to preamble search
                frame.time_out <= 1'b1;
                frame.legal    <= 1'b0;
                in_frame       <= 1'b0;
                bit_cnt        <= '0;
                to_cnt         <= '0;
                ones_cnt       <= '0;
            end else if (mdc_rise) begin
                to_cnt <= '0;
                if (in_frame || frame_start) begin
                    ones_cnt <= '0;
                    bit_cnt  <= bit_cnt + 6'd1;
                    if (frame_start) begin
                        in_frame    <= 1'b1;
                        frame.legal <= 1'b0;
                    end
                    // Last phyad bit arrives with count 8
                    if (bit_cnt == 6'd8) begin
                        frame.phyaddr_done <= 1'b1;
                        frame.legal <= ({frame.rx_data.cl22.phyad[4:1], mdio_bit} == PHY_ADDR);
                    end
                    if (bit_cnt == 6'd13) begin
                        frame.info_done <= 1'b1;
                    end
                    if (bit_cnt == 6'd31) begin
                        frame.data_done <= 1'b1;
                        in_frame        <= 1'b0;
                        bit_cnt         <= '0;
                    end
                end else if (mdio_bit) begin
                    if (ones_cnt != 6'd32) begin
                        ones_cnt <= ones_cnt + 6'd1;
                    end
                end else begin
                    ones_cnt <= '0;
                end
            end else if (in_frame) begin
                to_cnt <= to_cnt + 1'b1;
            end
        end
    end

    // Frame bits land in place, MSB first
    always_ff @(posedge clk_25m) begin
        if (mdc_rise && (in_frame || frame_start)) begin
            frame.rx_data[~bit_cnt[4:0]] <= mdio_bit;
        end
    end

    // --------------------
    // Read data out
    // Counts 15 to 31 cover the second turnaround bit and 16 data bits
    assign drive = in_frame && frame.legal && frame.resp_ready &&
                   (bit_cnt >= 6'd15) && (bit_cnt <= 6'd31);

    always_ff @(posedge clk_25m) begin
        if (mdc_fall && drive) begin
            if (bit_cnt == 6'd15) begin
                tx_shift <= frame.resp_rdata;
            end else begin
                tx_shift <= {tx_shift[14:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            mdio_oe  <= 1'b0;
            mdio_out <= 1'b0;
        end else if (frame.time_out) begin
            mdio_oe  <= 1'b0;
            mdio_out <= 1'b0;
        end else if (mdc_fall) begin
            mdio_oe  <= drive;
            mdio_out <= drive && (bit_cnt != 6'd15) && tx_shift[15];
        end
    end

endmodule

// ==== src/mdio_slave_top.sv ====
// MDIO slave top level
// Frontend, clause dispatcher and PHY register store
`timescale 1ns/1ps
module mdio_slave_top #(
    parameter logic [4:0] PHY_ADDR       = 5'd3,
    parameter int         TIMEOUT_CYCLES = 64
) (
    input  logic clk_25m,
    input  logic rst_n,
    input  logic mdc,
    input  logic mdio_in,
    output logic mdio_out,
    output logic mdio_oe
);

    mdio_frame_if frame_if ();
    mdio_reg_if   reg_if ();

    mdio_slave_frontend #(
        .PHY_ADDR       (PHY_ADDR),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) i_frontend (
        .clk_25m  (clk_25m),
        .rst_n    (rst_n),
        .mdc      (mdc),
        .mdio_in  (mdio_in),
        .mdio_out (mdio_out),
        .mdio_oe  (mdio_oe),
        .frame    (frame_if)
    );

    mdio_slave_backend i_backend (
        .clk_25m (clk_25m),
        .rst_n   (rst_n),
        .frame   (frame_if),
        .reg_bus (reg_if)
    );

    mdio_phy_regs i_phy_regs (
        .clk_25m (clk_25m),
        .rst_n   (rst_n),
        .reg_bus (reg_if)
    );

endmodule

// ==== tb/mdio_checker.sv ====
// MDIO pin checker
// Decodes frames from the pins, keeps a reference register model and
// compares read data and output enable timing
`timescale 1ns/1ps
module mdio_checker #(
    parameter logic [4:0] PHY_ADDR       = 5'd3,
    parameter int         TIMEOUT_CYCLES = 64
) (
    input  logic clk_25m,
    input  logic rst_n,
    input  logic mdc,
    input  logic mdio_in,
    input  logic mdio_out,
    input  logic mdio_oe,
    output int   frames_seen,
    output int   pass_count,
    output int   err_count
);

    logic [15:0] model [128];
    logic [15:0] addr45;
    logic [31:0] word;
    logic [15:0] rd_bits;
    logic        mdc_q;
    logic        in_frame;
    logic        exp_oe;
    int          ones;
    int          bit_idx;
    int          idle;

    // Frames the DUT must answer on mdio_out
    function automatic logic answers_read(input logic [31:0] w);
        if (w[27:23] != PHY_ADDR) begin
            return 1'b0;
        end
        if (w[31:30] == 2'b01) begin
            return w[29:28] == 2'b10;
        end
        return (w[31:30] == 2'b00) && w[29];
    endfunction

    task automatic check_read(input string name, input logic [15:0] exp);
        if (rd_bits === exp) begin
            pass_count++;
            $display("ok       %s read %h", name, rd_bits);
        end else begin
            err_count++;
            $display("** Error %s: expected %h, actual %h", name, exp, rd_bits);
        end
    endtask

    // --------------------
    // Model update at the end of a complete frame
    task automatic finish_frame();
        logic [6:0] idx;
        string      name;
        frames_seen++;
        if (word[27:23] != PHY_ADDR) begin
            $display("ok       frame %0d ignored, PHY address %0d", frames_seen, word[27:23]);
        end else if (word[31:30] == 2'b01) begin
            // Clause 22 shares devad 0
            idx  = {2'b00, word[22:18]};
            name = $sformatf("frame %0d cl22 op %b reg %0d", frames_seen, word[29:28],
                             word[22:18]);
            if (word[29:28] == 2'b10) begin
                check_read(name, model[idx]);
            end else begin
                model[idx] = word[15:0];
                $display("ok       %s wrote %h", name, word[15:0]);
            end
        end else begin
            idx  = {word[19:18], addr45[4:0]};
            name = $sformatf("frame %0d cl45 op %b dev %0d addr %h", frames_seen,
                             word[29:28], word[22:18], addr45);
            case (word[29:28])
                2'b00:   addr45 = word[15:0];
                2'b01:   model[idx] = word[15:0];
                default: check_read(name, model[idx]);
            endcase
            if (word[29:28] == 2'b10) begin
                addr45 = addr45 + 16'd1;
            end
            if (!word[29]) begin
                $display("ok       %s data %h", name, word[15:0]);
            end
        end
    endtask

    always @(posedge clk_25m or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 128; i++) begin
                model[i] = 16'h0;
            end
            addr45      = 16'h0;
            mdc_q       = 1'b0;
            in_frame    = 1'b0;
            ones        = 0;
            bit_idx     = 0;
            idle        = 0;
            frames_seen = 0;
            pass_count  = 0;
            err_count   = 0;
        end else begin
            if (mdc && !mdc_q) begin
                idle = 0;
                if (!in_frame) begin
                    if (mdio_oe !== 1'b0) begin
                        err_count++;
                        $display("** Error idle after frame %0d mdio_oe: expected 0, actual %b",
                                 frames_seen, mdio_oe);
                    end
                    if (mdio_in) begin
                        ones++;
                    end else if (ones >= 32) begin
                        in_frame = 1'b1;
                        bit_idx  = 0;
                    end else begin
                        ones = 0;
                    end
                end
                if (in_frame) begin
                    word[31 - bit_idx] = mdio_in;
                    exp_oe = (bit_idx >= 15) && answers_read(word);
                    if (mdio_oe !== exp_oe) begin
                        err_count++;
                        $display("** Error frame %0d bit %0d mdio_oe: expected %b, actual %b",
                                 frames_seen + 1, bit_idx, exp_oe, mdio_oe);
                    end
                    if (bit_idx == 15 && mdio_oe && mdio_out !== 1'b0) begin
                        err_count++;
                        $display("** Error frame %0d turnaround: expected 0, actual %b",
                                 frames_seen + 1, mdio_out);
                    end
                    if (bit_idx >= 16) begin
                        rd_bits[31 - bit_idx] = mdio_out;
                    end
                    bit_idx++;
                    if (bit_idx == 32) begin
                        in_frame = 1'b0;
                        ones     = 0;
                        finish_frame();
                    end
                end
            end else if (in_frame) begin
                idle++;
                // The DUT drops a frame once mdc stops
                if (idle > TIMEOUT_CYCLES) begin
                    frames_seen++;
                    in_frame = 1'b0;
                    ones     = 0;
                    $display("ok       frame %0d abandoned after mdc stopped", frames_seen);
                end
            end
            mdc_q = mdc;
        end
    end

endmodule

// ==== tb/tb_mdio_slave.sv ====
// MDIO slave testbench
// Seeded random MDIO master traffic for both clauses, wrong PHY address
// and abandoned frames, checked by the pin checker
`timescale 1ns/1ps
module tb_mdio_slave;

    localparam logic [4:0] PHY_ADDR       = 5'd3;
    localparam int         TIMEOUT_CYCLES = 64;

    logic        clk_25m;
    logic        rst_n;
    logic        mdc;
    logic        mdio_in;
    logic        mdio_out;
    logic        mdio_oe;
    integer      seed;
    logic [31:0] rnd;
    logic [15:0] data;
    logic [15:0] base;
    logic [4:0]  devad;
    int          frames_sent;
    int          frames_seen;
    int          pass_count;
    int          err_count;
    int          wait_cnt;
    logic        timed_out;

    always #20 clk_25m = ~clk_25m;

    mdio_slave_top #(
        .PHY_ADDR       (PHY_ADDR),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) i_mdio_slave_top (
        .clk_25m  (clk_25m),
        .rst_n    (rst_n),
        .mdc      (mdc),
        .mdio_in  (mdio_in),
        .mdio_out (mdio_out),
        .mdio_oe  (mdio_oe)
    );

    mdio_checker #(
        .PHY_ADDR       (PHY_ADDR),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) i_checker (
        .clk_25m     (clk_25m),
        .rst_n       (rst_n),
        .mdc         (mdc),
        .mdio_in     (mdio_in),
        .mdio_out    (mdio_out),
        .mdio_oe     (mdio_oe),
        .frames_seen (frames_seen),
        .pass_count  (pass_count),
        .err_count   (err_count)
    );

    function automatic logic [31:0] cl22_frame(input logic [1:0] op, input logic [4:0] phy,
                                               input logic [4:0] regad, input logic [15:0] d);
        return {2'b01, op, phy, regad, 2'b10, d};
    endfunction

    function automatic logic [31:0] cl45_frame(input logic [1:0] op, input logic [4:0] phy,
                                               input logic [4:0] dev, input logic [15:0] d);
        return {2'b00, op, phy, dev, 2'b10, d};
    endfunction

    // One mdc period of 8 clocks, data changes with the falling edge
    task automatic drive_bit(input logic b);
        mdc     <= 1'b0;
        mdio_in <= b;
        repeat (4) @(posedge clk_25m);
        mdc <= 1'b1;
        repeat (4) @(posedge clk_25m);
    endtask

    // Preamble, then the first nbits of the frame
    task automatic send_frame(input logic [31:0] word, input int nbits);
        logic is_read;
        is_read = (word[31:30] == 2'b01) ? (word[29:28] == 2'b10) : word[29];
        repeat (32) drive_bit(1'b1);
        for (int i = 31; i > 31 - nbits; i--) begin
            // Reads release mdio from the first turnaround bit on
            drive_bit((is_read && i <= 17) ? 1'b1 : word[i]);
        end
        frames_sent++;
    endtask

    initial begin
        seed        = 32'h6e48_f0cb;
        clk_25m     = 1'b0;
        rst_n       = 1'b0;
        mdc         = 1'b0;
        mdio_in     = 1'b1;
        frames_sent = 0;
        timed_out   = 1'b0;
        repeat (3) @(posedge clk_25m);
        rst_n <= 1'b1;
        @(posedge clk_25m);

        // --------------------
        // Clause 22
        rnd  = $random(seed);
        data = rnd[15:0];
        send_frame(cl22_frame(2'b01, PHY_ADDR, 5'd7, data), 32);
        send_frame(cl22_frame(2'b10, PHY_ADDR, 5'd7, 16'h0), 32);
        repeat (16) begin
            rnd = $random(seed);
            send_frame(cl22_frame(rnd[20] ? 2'b10 : 2'b01, PHY_ADDR, rnd[4:0], rnd[31:16]), 32);
        end

        // --------------------
        // Clause 45 address, write, read back and one random access
        repeat (10) begin
            rnd   = $random(seed);
            devad = 5'd1 + 5'(rnd[7:0] % 3);
            send_frame(cl45_frame(2'b00, PHY_ADDR, devad, rnd[31:16]), 32);
            send_frame(cl45_frame(2'b01, PHY_ADDR, devad, rnd[23:8]), 32);
            send_frame(cl45_frame(2'b11, PHY_ADDR, devad, 16'h0), 32);
            rnd = $random(seed);
            send_frame(cl45_frame(rnd[9:8], PHY_ADDR, 5'd1 + 5'(rnd[7:0] % 3), rnd[31:16]), 32);
        end
        // Address bits above 4 fold onto the same word, devad does not
        rnd = $random(seed);
        send_frame(cl45_frame(2'b00, PHY_ADDR, 5'd2, 16'h0105), 32);
        send_frame(cl45_frame(2'b01, PHY_ADDR, 5'd2, rnd[15:0]), 32);
        send_frame(cl45_frame(2'b00, PHY_ADDR, 5'd2, 16'h0005), 32);
        send_frame(cl45_frame(2'b11, PHY_ADDR, 5'd2, 16'h0), 32);
        send_frame(cl45_frame(2'b11, PHY_ADDR, 5'd1, 16'h0), 32);
        send_frame(cl22_frame(2'b10, PHY_ADDR, 5'd5, 16'h0), 32);

        // --------------------
        // Post-read-increment chain over five fresh words
        rnd  = $random(seed);
        base = rnd[15:0];
        for (int k = 0; k < 5; k++) begin
            rnd = $random(seed);
            send_frame(cl45_frame(2'b00, PHY_ADDR, 5'd3, base + 16'(k)), 32);
            send_frame(cl45_frame(2'b01, PHY_ADDR, 5'd3, rnd[15:0]), 32);
        end
        send_frame(cl45_frame(2'b00, PHY_ADDR, 5'd3, base), 32);
        repeat (4) send_frame(cl45_frame(2'b10, PHY_ADDR, 5'd3, 16'h0), 32);
        // Plain read lands on base + 4
        send_frame(cl45_frame(2'b11, PHY_ADDR, 5'd3, 16'h0), 32);

        // --------------------
        // Wrong PHY address, then legal reads of the same words
        send_frame(cl22_frame(2'b01, PHY_ADDR ^ 5'd1, 5'd7, ~data), 32);
        send_frame(cl22_frame(2'b10, PHY_ADDR ^ 5'd4, 5'd7, 16'h0), 32);
        send_frame(cl45_frame(2'b01, PHY_ADDR ^ 5'd8, 5'd3, ~data), 32);
        send_frame(cl45_frame(2'b11, PHY_ADDR ^ 5'd2, 5'd3, 16'h0), 32);
        send_frame(cl22_frame(2'b10, PHY_ADDR, 5'd7, 16'h0), 32);
        send_frame(cl45_frame(2'b11, PHY_ADDR, 5'd3, 16'h0), 32);

        // Write abandoned in the data field, mdc held high past the timeout
        send_frame(cl22_frame(2'b01, PHY_ADDR, 5'd7, ~data), 24);
        repeat (TIMEOUT_CYCLES + 40) @(posedge clk_25m);
        send_frame(cl22_frame(2'b10, PHY_ADDR, 5'd7, 16'h0), 32);

        wait_cnt = 0;
        while (frames_seen != frames_sent && !timed_out) begin
            @(posedge clk_25m);
            wait_cnt++;
            if (wait_cnt > 2000) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("Timed out waiting for the checker, %0d of %0d frames decoded",
                     frames_seen, frames_sent);
        end
        $display("Frames %0d, reads passed %0d, errors %0d", frames_seen, pass_count, err_count);
        if (!timed_out && err_count == 0 && pass_count > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/mdio_pkg.sv
src/mdio_frame_if.sv
src/mdio_reg_if.sv
src/mdio_phy_regs.sv
src/mdio_slave_22_backend.sv
src/mdio_slave_45_backend.sv
src/mdio_slave_backend.sv
src/mdio_slave_frontend.sv
src/mdio_slave_top.sv
tb/mdio_checker.sv
tb/tb_mdio_slave.sv
